// ==== src/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Width of one memory word and of all data paths
`define MEM_DATA_W 32

// Byte address width, 4 KiB of memory
`define MEM_ADDR_W 12

// Words in the data memory
`define MEM_DEPTH_WORDS 1024

`endif

// ==== src/mem_ops_pkg.sv ====
package mem_ops_pkg;

    // Load/store opcodes with loads in the low half of the code space
    typedef enum logic [3:0] {
        OP_LB  = 4'h0,
        OP_LBU = 4'h1,
        OP_LH  = 4'h2,
        OP_LHU = 4'h3,
        OP_LW  = 4'h4,
        OP_SB  = 4'h8,
        OP_SH  = 4'h9,
        OP_SW  = 4'hA
    } mem_op_e;

    // Access size of one transfer
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b01,
        SIZE_HALF = 2'b10,
        SIZE_WORD = 2'b11
    } mem_size_e;

    // True for SB, SH, SW
    function automatic logic op_is_store(mem_op_e op);
        return (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
    endfunction

    // Byte, half or word access of an opcode
    function automatic mem_size_e op_size(mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return SIZE_BYTE;
            OP_LH, OP_LHU, OP_SH: return SIZE_HALF;
            default:              return SIZE_WORD;
        endcase
    endfunction

    // Sign extension only for LB and LH
    function automatic logic op_is_signed(mem_op_e op);
        return (op == OP_LB) || (op == OP_LH);
    endfunction

endpackage

// ==== src/mem_ctrl_pkg.sv ====
package mem_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Stage controller
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        CTRL_IDLE      = 3'd0,  // Waiting for i_req
        CTRL_ALIGN_CHK = 3'd1,  // Request latched, check alignment
        CTRL_BUS_REQ   = 3'd2,  // Bus req high, waiting for ack
        CTRL_BUS_REL   = 3'd3,  // Bus req dropped, waiting for ack low
        CTRL_DONE      = 3'd4   // o_ack high until i_req falls
    } ctrl_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Data memory
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        DMEM_IDLE    = 2'd0,
        DMEM_ACK     = 2'd1,
        DMEM_RELEASE = 2'd2
    } dmem_state_e;

endpackage

// ==== src/mem_bus_if.sv ====
`include "mem_macros.svh"

// Internal four-phase bus between controller and data memory
interface mem_bus_if;

    // Handshake
    logic                        req;
    logic                        ack;

    // Request fields, stable from req high until ack low
    logic                        we;
    logic [`MEM_ADDR_W-3:0]      addr;    // Word index
    logic [`MEM_DATA_W-1:0]      wdata;
    logic [`MEM_DATA_W/8-1:0]    be;

    // Read word, valid while ack is high
    logic [`MEM_DATA_W-1:0]      rdata;

    // Controller side
    modport master (
        output req,
        output we,
        output addr,
        output wdata,
        output be,
        input  rdata,
        input  ack
    );

    // Memory side
    modport slave (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        input  be,
        output rdata,
        output ack
    );

endinterface

// ==== src/lsu_align.sv ====
`include "mem_macros.svh"

module lsu_align
    import mem_ops_pkg::*;
(
    input  mem_op_e                  i_op,
    input  logic [`MEM_ADDR_W-1:0]   i_addr,
    input  logic [`MEM_DATA_W-1:0]   i_wdata,
    input  logic [`MEM_DATA_W-1:0]   i_rdata,
    output logic                     o_misaligned,
    output logic [`MEM_DATA_W-1:0]   o_store_data,
    output logic [`MEM_DATA_W/8-1:0] o_be,
    output logic [`MEM_DATA_W-1:0]   o_load_data
);

    mem_size_e  size;
    logic [1:0] lane;
    logic [7:0] byte_sel;
    logic [15:0] half_sel;

    assign size = op_size(i_op);
    assign lane = i_addr[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Alignment check
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (size)
            SIZE_HALF: o_misaligned = lane[0];
            SIZE_WORD: o_misaligned = |lane;
            default:   o_misaligned = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Store side
    ////////////////////////////////////////////////////////////////////////////

    // Replicate the value over all lanes, the enables pick the real one
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                o_store_data = {4{i_wdata[7:0]}};
                o_be         = 4'b0001 << lane;
            end
            SIZE_HALF: begin
                o_store_data = {2{i_wdata[15:0]}};
                o_be         = lane[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_store_data = i_wdata;
                o_be         = 4'b1111;
            end
        endcase
        // Loads never write
        if (!op_is_store(i_op)) begin
            o_be = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Load side
    ////////////////////////////////////////////////////////////////////////////

    // Little-endian, lane 0 is the low byte
    assign byte_sel = i_rdata[8*lane +: 8];
    assign half_sel = lane[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        case (size)
            SIZE_BYTE: begin
                if (op_is_signed(i_op))
                    o_load_data = {{(`MEM_DATA_W-8){byte_sel[7]}}, byte_sel};
                else
                    o_load_data = {{(`MEM_DATA_W-8){1'b0}}, byte_sel};
            end
            SIZE_HALF: begin
                if (op_is_signed(i_op))
                    o_load_data = {{(`MEM_DATA_W-16){half_sel[15]}}, half_sel};
                else
                    o_load_data = {{(`MEM_DATA_W-16){1'b0}}, half_sel};
            end
            default: o_load_data = i_rdata;
        endcase
    end

endmodule

// ==== src/load_store_ctrl.sv ====
`include "mem_macros.svh"

module load_store_ctrl
    import mem_ops_pkg::*;
    import mem_ctrl_pkg::*;
(
    input  logic                     i_clock,
    input  logic                     i_rst_n,
    // External request
    input  logic                     i_req,
    input  mem_op_e                  i_op,
    input  logic [`MEM_ADDR_W-1:0]   i_addr,
    input  logic [`MEM_DATA_W-1:0]   i_wdata,
    // From the aligner
    input  logic                     i_misaligned,
    input  logic [`MEM_DATA_W-1:0]   i_store_data,
    input  logic [`MEM_DATA_W/8-1:0] i_be,
    input  logic [`MEM_DATA_W-1:0]   i_load_data,
    // To the aligner
    output mem_op_e                  o_lat_op,
    output logic [`MEM_ADDR_W-1:0]   o_lat_addr,
    output logic [`MEM_DATA_W-1:0]   o_lat_wdata,
    output logic [`MEM_DATA_W-1:0]   o_lat_rdata,
    // External response
    output logic                     o_ack,
    output logic [`MEM_DATA_W-1:0]   o_rdata,
    output logic                     o_misaligned,
    // Internal bus
    mem_bus_if.master                bus
);

    ctrl_state_e              state_q;
    mem_op_e                  lat_op_q;
    logic [`MEM_ADDR_W-1:0]   lat_addr_q;
    logic [`MEM_DATA_W-1:0]   lat_wdata_q;
    logic                     bus_req_q;
    logic                     ack_q;
    logic                     misaligned_q;
    logic [`MEM_DATA_W-1:0]   rdata_q;

    ////////////////////////////////////////////////////////////////////////////
    // Request latch
    ////////////////////////////////////////////////////////////////////////////

    // Captured once per request, held until the next one
    always_ff @(posedge i_clock) begin
        if (state_q == CTRL_IDLE && i_req) begin
            lat_op_q    <= i_op;
            lat_addr_q  <= i_addr;
            lat_wdata_q <= i_wdata;
        end
    end

    assign o_lat_op    = lat_op_q;
    assign o_lat_addr  = lat_addr_q;
    assign o_lat_wdata = lat_wdata_q;
    // Raw word goes back through the aligner for extraction
    assign o_lat_rdata = bus.rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q      <= CTRL_IDLE;
            bus_req_q    <= 1'b0;
            ack_q        <= 1'b0;
            misaligned_q <= 1'b0;
            rdata_q      <= '0;
        end else begin
            case (state_q)
                CTRL_IDLE: begin
                    if (i_req) begin
                        misaligned_q <= 1'b0;
                        rdata_q      <= '0;
                        state_q      <= CTRL_ALIGN_CHK;
                    end
                end
                CTRL_ALIGN_CHK: begin
                    // Misaligned access skips memory entirely
                    if (i_misaligned) begin
                        misaligned_q <= 1'b1;
                        ack_q        <= 1'b1;
                        state_q      <= CTRL_DONE;
                    end else begin
                        bus_req_q <= 1'b1;
                        state_q   <= CTRL_BUS_REQ;
                    end
                end
                CTRL_BUS_REQ: begin
                    if (bus.ack) begin
                        // Stores answer with zero
                        rdata_q   <= op_is_store(lat_op_q) ? '0 : i_load_data;
                        bus_req_q <= 1'b0;
                        state_q   <= CTRL_BUS_REL;
                    end
                end
                CTRL_BUS_REL: begin
                    if (!bus.ack) begin
                        ack_q   <= 1'b1;
                        state_q <= CTRL_DONE;
                    end
                end
                CTRL_DONE: begin
                    // Hold o_ack until the requester lets go
                    if (!i_req) begin
                        ack_q   <= 1'b0;
                        state_q <= CTRL_IDLE;
                    end
                end
                default: state_q <= CTRL_IDLE;
            endcase
        end
    end

    // Bus fields come from the latch, stable for the whole transfer
    assign bus.req   = bus_req_q;
    assign bus.we    = op_is_store(lat_op_q);
    assign bus.addr  = lat_addr_q[`MEM_ADDR_W-1:2];
    assign bus.wdata = i_store_data;
    assign bus.be    = i_be;

    assign o_ack        = ack_q;
    assign o_rdata      = rdata_q;
    assign o_misaligned = misaligned_q;

endmodule

// ==== src/data_mem.sv ====
`include "mem_macros.svh"

module data_mem
    import mem_ctrl_pkg::*;
(
    input  logic      i_clock,
    input  logic      i_rst_n,
    mem_bus_if.slave  bus
);

    logic [`MEM_DATA_W-1:0] mem_q [`MEM_DEPTH_WORDS];
    dmem_state_e            state_q;
    logic                   ack_q;
    logic [`MEM_DATA_W-1:0] rdata_q;

    ////////////////////////////////////////////////////////////////////////////
    // Slave FSM and storage
    ////////////////////////////////////////////////////////////////////////////

    // Access happens on the edge that sees req, ack rises on that edge
    always_ff @(posedge i_clock or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `MEM_DEPTH_WORDS; i++) begin
                mem_q[i] <= '0;
            end
            state_q <= DMEM_IDLE;
            ack_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            case (state_q)
                DMEM_IDLE: begin
                    if (bus.req) begin
                        if (bus.we) begin
                            // Only the enabled lanes change
                            for (int b = 0; b < `MEM_DATA_W/8; b++) begin
                                if (bus.be[b]) begin
                                    mem_q[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                                end
                            end
                        end else begin
                            rdata_q <= mem_q[bus.addr];
                        end
                        ack_q   <= 1'b1;
                        state_q <= DMEM_ACK;
                    end
                end
                DMEM_ACK: begin
                    // Wait for the master to drop req
                    if (!bus.req) begin
                        ack_q   <= 1'b0;
                        state_q <= DMEM_RELEASE;
                    end
                end
                DMEM_RELEASE: begin
                    // Ack is low now, ready for the next request
                    state_q <= DMEM_IDLE;
                end
                default: state_q <= DMEM_IDLE;
            endcase
        end
    end

    assign bus.ack   = ack_q;
    assign bus.rdata = rdata_q;

endmodule

// ==== src/mem_stage_top.sv ====
`include "mem_macros.svh"

module mem_stage_top
    import mem_ops_pkg::*;
(
    input  logic                   i_clock,
    input  logic                   i_rst_n,
    input  logic                   i_req,
    input  mem_op_e                i_op,
    input  logic [`MEM_ADDR_W-1:0] i_addr,
    input  logic [`MEM_DATA_W-1:0] i_wdata,
    output logic                   o_ack,
    output logic                   o_misaligned,
    output logic [`MEM_DATA_W-1:0] o_rdata
);

    // Aligner results
    logic                     misaligned;
    logic [`MEM_DATA_W-1:0]   store_data;
    logic [`MEM_DATA_W/8-1:0] be;
    logic [`MEM_DATA_W-1:0]   load_data;

    // Latched request and raw word toward the aligner
    mem_op_e                  lat_op;
    logic [`MEM_ADDR_W-1:0]   lat_addr;
    logic [`MEM_DATA_W-1:0]   lat_wdata;
    logic [`MEM_DATA_W-1:0]   lat_rdata;

    mem_bus_if u_bus ();

    load_store_ctrl u_ctrl (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_req        (i_req),
        .i_op         (i_op),
        .i_addr       (i_addr),
        .i_wdata      (i_wdata),
        .i_misaligned (misaligned),
        .i_store_data (store_data),
        .i_be         (be),
        .i_load_data  (load_data),
        .o_lat_op     (lat_op),
        .o_lat_addr   (lat_addr),
        .o_lat_wdata  (lat_wdata),
        .o_lat_rdata  (lat_rdata),
        .o_ack        (o_ack),
        .o_rdata      (o_rdata),
        .o_misaligned (o_misaligned),
        .bus          (u_bus.master)
    );

    lsu_align u_align (
        .i_op         (lat_op),
        .i_addr       (lat_addr),
        .i_wdata      (lat_wdata),
        .i_rdata      (lat_rdata),
        .o_misaligned (misaligned),
        .o_store_data (store_data),
        .o_be         (be),
        .o_load_data  (load_data)
    );

    data_mem u_dmem (
        .i_clock (i_clock),
        .i_rst_n (i_rst_n),
        .bus     (u_bus.slave)
    );

endmodule

// ==== dv/tb_clock_gen.sv ====
module tb_clock_gen (
    output logic o_clock
);

    // Period of 10, starts low so the first edge is a rising one at 5
    initial begin
        o_clock = 1'b0;
        forever begin
            #5 o_clock = ~o_clock;
        end
    end

endmodule

// ==== dv/mem_stage_checker.sv ====
`include "mem_macros.svh"

module mem_stage_checker (
    input logic                                                 i_clock,
    input logic                                                 i_rst_n,
    input logic                                                 i_req,
    input logic                                                 i_ack,
    input logic                                                 i_bus_req,
    input logic                                                 i_bus_ack,
    // we, word index, wdata and byte enables side by side
    input logic [`MEM_ADDR_W+`MEM_DATA_W+`MEM_DATA_W/8-2:0]     i_bus_fields
);

    // Read by the testbench top
    int error_count = 0;

    // o_ack only comes up under a live request
    assert property (@(posedge i_clock) disable iff (!i_rst_n) $rose(i_ack) |-> i_req)
        else begin
            error_count++;
            $error("o_ack rose while i_req was low");
        end

    // Memory answers, it never starts a transfer
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        $rose(i_bus_ack) |-> $past(i_bus_req))
        else begin
            error_count++;
            $error("bus ack rose without a prior bus req");
        end

    // Request fields frozen during the transfer
    assert property (@(posedge i_clock) disable iff (!i_rst_n)
        i_bus_req && $past(i_bus_req) |-> $stable(i_bus_fields))
        else begin
            error_count++;
            $error("bus fields changed while bus req was high");
        end

    // Bounded latency
    assert property (@(posedge i_clock) disable iff (!i_rst_n) $rose(i_req) |-> ##[1:8] i_ack)
        else begin
            error_count++;
            $error("no o_ack within 8 cycles of i_req");
        end

endmodule

bind mem_stage_top mem_stage_checker u_checker (
    .i_clock      (i_clock),
    .i_rst_n      (i_rst_n),
    .i_req        (i_req),
    .i_ack        (o_ack),
    .i_bus_req    (u_bus.req),
    .i_bus_ack    (u_bus.ack),
    .i_bus_fields ({u_bus.we, u_bus.addr, u_bus.wdata, u_bus.be})
);

// ==== dv/tb_mem_stage.sv ====
`include "mem_macros.svh"

module tb_mem_stage
    import mem_ops_pkg::*;
();

    localparam int NUM_RANDOM  = 400;
    localparam int ACK_TIMEOUT = 16;
    localparam int REL_TIMEOUT = 4;

    logic                   clock;
    logic                   rst_n;
    logic                   req;
    mem_op_e                op;
    logic [`MEM_ADDR_W-1:0] addr;
    logic [`MEM_DATA_W-1:0] wdata;
    logic                   ack;
    logic                   misaligned;
    logic [`MEM_DATA_W-1:0] rdata;

    // Little-endian reference memory with one entry per byte address
    logic [7:0] model_mem [1 << `MEM_ADDR_W];

    int   req_count = 0;
    int   ack_rises = 0;
    logic ack_prev  = 1'b0;

    tb_clock_gen u_clk (.o_clock(clock));

    mem_stage_top uut (
        .i_clock      (clock),
        .i_rst_n      (rst_n),
        .i_req        (req),
        .i_op         (op),
        .i_addr       (addr),
        .i_wdata      (wdata),
        .o_ack        (ack),
        .o_misaligned (misaligned),
        .o_rdata      (rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Failure handling and compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic end_in_failure();
        $display("*** FAILED ***");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_equal(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error: time %0t: %s is %h, expected %h", $time, what, got, expected);
            end_in_failure();
        end
    endtask

    // Count rising edges of o_ack at mid-cycle
    always @(negedge clock) begin
        if (ack && !ack_prev) begin
            ack_rises++;
        end
        ack_prev = ack;
        if (uut.u_checker.error_count != 0) begin
            $display("a checker assertion failed, see the error above");
            end_in_failure();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    task automatic model_apply(input mem_op_e m_op, input logic [`MEM_ADDR_W-1:0] m_addr,
                               input logic [31:0] m_wdata, output logic [31:0] exp_rdata,
                               output logic exp_mis);
        int          nbytes;
        int          i;
        logic [31:0] raw;
        nbytes = (m_op inside {OP_LB, OP_LBU, OP_SB}) ? 1 :
                 (m_op inside {OP_LH, OP_LHU, OP_SH}) ? 2 : 4;
        // Natural alignment or nothing happens
        exp_mis   = (m_addr % nbytes) != 0;
        exp_rdata = '0;
        raw       = '0;
        if (!exp_mis) begin
            for (i = 0; i < nbytes; i++) begin
                if (m_op inside {OP_SB, OP_SH, OP_SW})
                    model_mem[m_addr + i] = m_wdata[8*i +: 8];
                else
                    raw[8*i +: 8] = model_mem[m_addr + i];
            end
            case (m_op)
                OP_LB:                 exp_rdata = {{24{raw[7]}}, raw[7:0]};
                OP_LH:                 exp_rdata = {{16{raw[15]}}, raw[15:0]};
                OP_LBU, OP_LHU, OP_LW: exp_rdata = raw;
                default:               exp_rdata = '0;
            endcase
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic mem_op_e random_op();
        case ($urandom % 8)
            0:       return OP_LB;
            1:       return OP_LBU;
            2:       return OP_LH;
            3:       return OP_LHU;
            4:       return OP_LW;
            5:       return OP_SB;
            6:       return OP_SH;
            default: return OP_SW;
        endcase
    endfunction

    function automatic logic [`MEM_ADDR_W-1:0] random_addr(input mem_op_e r_op);
        logic [`MEM_ADDR_W-1:0] a;
        // Mostly a small window so loads hit earlier stores
        if ($urandom % 4 == 0)
            a = `MEM_ADDR_W'($urandom);
        else
            a = `MEM_ADDR_W'($urandom % 64);
        // Bias toward aligned accesses
        if ($urandom % 10 < 7) begin
            if (r_op inside {OP_LH, OP_LHU, OP_SH})
                a[0] = 1'b0;
            else if (r_op inside {OP_LW, OP_SW})
                a[1:0] = 2'b00;
        end
        return a;
    endfunction

    // Full four-phase cycle with i_req held for extra cycles after o_ack
    task automatic do_request(input mem_op_e r_op, input logic [`MEM_ADDR_W-1:0] r_addr,
                              input logic [31:0] r_wdata, input int hold,
                              output logic [31:0] got_rdata, output logic got_mis);
        int cycles;
        int k;
        @(posedge clock);
        req   <= 1'b1;
        op    <= r_op;
        addr  <= r_addr;
        wdata <= r_wdata;
        req_count++;
        cycles = 0;
        @(negedge clock);
        while (!ack) begin
            if (cycles >= ACK_TIMEOUT) begin
                $display("timeout: o_ack did not rise within %0d cycles", ACK_TIMEOUT);
                end_in_failure();
            end
            cycles++;
            @(negedge clock);
        end
        got_rdata = rdata;
        got_mis   = misaligned;
        for (k = 0; k < hold; k++) begin
            @(negedge clock);
            check_equal("o_ack while i_req held", 32'(ack), 32'd1);
        end
        @(posedge clock);
        req <= 1'b0;
        // o_ack must be gone before the next request goes out
        cycles = 0;
        @(negedge clock);
        while (ack) begin
            if (cycles >= REL_TIMEOUT) begin
                $display("timeout: o_ack stayed high after i_req dropped");
                end_in_failure();
            end
            cycles++;
            @(negedge clock);
        end
    endtask

    task automatic run_and_check(input mem_op_e r_op, input logic [`MEM_ADDR_W-1:0] r_addr,
                                 input logic [31:0] r_wdata, input int hold);
        logic [31:0] exp_rdata;
        logic        exp_mis;
        logic [31:0] got_rdata;
        logic        got_mis;
        model_apply(r_op, r_addr, r_wdata, exp_rdata, exp_mis);
        do_request(r_op, r_addr, r_wdata, hold, got_rdata, got_mis);
        check_equal($sformatf("o_misaligned of %s at %h", r_op.name(), r_addr),
                    32'(got_mis), 32'(exp_mis));
        check_equal($sformatf("o_rdata of %s at %h", r_op.name(), r_addr),
                    got_rdata, exp_rdata);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        mem_op_e r_op;
        int      n;
        void'($urandom(32'h26509b75));
        rst_n = 1'b0;
        req   = 1'b0;
        op    = OP_LW;
        addr  = '0;
        wdata = '0;
        // Memory comes out of reset all zero
        for (n = 0; n < (1 << `MEM_ADDR_W); n++) begin
            model_mem[n] = 8'h00;
        end
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;

        // Idle outputs after reset
        @(negedge clock);
        check_equal("o_ack after reset", 32'(ack), 32'd0);
        check_equal("o_misaligned after reset", 32'(misaligned), 32'd0);
        check_equal("o_rdata after reset", rdata, 32'd0);

        // Word round trip
        run_and_check(OP_SW, 12'h100, 32'hA5C3_7E81, 0);
        run_and_check(OP_LW, 12'h100, 32'h0, 1);
        // Byte and halfword merge into one word with nonzero neighbours
        run_and_check(OP_SW, 12'h104, 32'h5A3C_D2E1, 0);
        run_and_check(OP_SB, 12'h105, 32'h1234_569F, 0);
        run_and_check(OP_SH, 12'h106, 32'h7777_BEEF, 2);
        run_and_check(OP_LW, 12'h104, 32'h0, 0);
        // Sign and zero extension
        run_and_check(OP_LB, 12'h105, 32'h0, 0);
        run_and_check(OP_LBU, 12'h105, 32'h0, 3);
        run_and_check(OP_LH, 12'h106, 32'h0, 0);
        run_and_check(OP_LHU, 12'h106, 32'h0, 1);
        // Misaligned accesses leave memory alone
        run_and_check(OP_SW, 12'h102, 32'hDEAD_BEEF, 0);
        run_and_check(OP_SH, 12'h101, 32'hCAFE_F00D, 0);
        run_and_check(OP_LW, 12'h103, 32'h0, 0);
        run_and_check(OP_LH, 12'h105, 32'h0, 0);
        run_and_check(OP_LW, 12'h100, 32'h0, 0);
        run_and_check(OP_LW, 12'h104, 32'h0, 0);

        // Random mix with random hold times
        for (n = 0; n < NUM_RANDOM; n++) begin
            r_op = random_op();
            run_and_check(r_op, random_addr(r_op), $urandom, int'($urandom % 4));
        end

        check_equal("o_ack rising edges", 32'(ack_rises), 32'(req_count));
        @(negedge clock);
        if (uut.u_checker.error_count != 0) begin
            $display("a checker assertion failed, see the error above");
            end_in_failure();
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

// ==== sources.f ====
+incdir+src
src/mem_ops_pkg.sv
src/mem_ctrl_pkg.sv
src/mem_bus_if.sv
src/lsu_align.sv
src/load_store_ctrl.sv
src/data_mem.sv
src/mem_stage_top.sv
dv/tb_clock_gen.sv
dv/mem_stage_checker.sv
dv/tb_mem_stage.sv
